//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert --timescale 1ns/10ps -Wno-fatal
TOP = timer_tb
FLIST = flist.f
OBJ_DIR = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
+incdir+include
hw/timer_bus_pkg.sv
hw/timer_core_pkg.sv
hw/timer_cmd_if.sv
hw/timer_bus_decode.sv
hw/timer_counters.sv
hw/timer_read_result.sv
hw/timer_top.sv
tests/tb_clock_gen.sv
tests/timer_tb.sv

//--- hw/timer_bus_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "timer_cfg.svh"

module timer_bus_decode import timer_bus_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input logic i_rw,
	input timer_reg_e i_address,
	input logic [`TIMER_DATA_WIDTH - 1:0] i_wdata,
	timer_cmd_if.source o_cmd
);

	logic request_q;
	logic request_rise;

	// A held request only counts once on its first sampled cycle.
	assign request_rise = i_request && !request_q;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			request_q <= 1'b0;
		end
		else begin
			request_q <= i_request;
		end
	end

	// ****************************************
	// Command strobe and opcode.
	// ****************************************

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_cmd.strobe <= 1'b0;
			o_cmd.op <= OP_NONE;
		end
		else begin
			o_cmd.strobe <= request_rise;
			if (request_rise) begin
				o_cmd.op <= i_rw ? OP_WRITE : OP_READ;
			end
			else begin
				o_cmd.op <= OP_NONE;
			end
		end
	end

	// Payload is captured with the strobe.
	always_ff @(posedge i_clock) begin
		if (request_rise) begin
			o_cmd.reg_sel <= i_address;
			o_cmd.wdata <= i_wdata;
		end
	end

	// The master keeps the access fields steady while the request is held.
	request_payload_stable: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_request && request_q |-> $stable(i_address) && $stable(i_rw) && $stable(i_wdata)
	);

endmodule

`default_nettype wire

//--- hw/timer_bus_pkg.sv
`default_nettype none

package timer_bus_pkg;

	// ****************************************
	// Register map, one word per address.
	// ****************************************
	typedef enum logic [3:0] {
		REG_MS      = 4'd0,
		REG_CNT0_LO = 4'd1,
		REG_CNT0_HI = 4'd2,
		REG_CNT1_LO = 4'd3,
		REG_CNT1_HI = 4'd4,
		REG_CNT2_LO = 4'd5,
		REG_CNT2_HI = 4'd6,
		REG_CNT3_LO = 4'd7,
		REG_CNT3_HI = 4'd8,
		REG_CMP_LO  = 4'd9,
		REG_CMP_HI  = 4'd10,
		REG_ENABLE  = 4'd14,
		REG_RAISE   = 4'd15
	} timer_reg_e;

	// Decoded access kind.
	typedef enum logic [1:0] {
		OP_NONE  = 2'd0,
		OP_READ  = 2'd1,
		OP_WRITE = 2'd2
	} timer_op_e;

endpackage

`default_nettype wire

//--- hw/timer_cmd_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "timer_cfg.svh"

interface timer_cmd_if import timer_bus_pkg::*; ();

	// One-cycle command, payload valid only while strobe is high.
	logic strobe;
	timer_op_e op;
	timer_reg_e reg_sel;
	logic [`TIMER_DATA_WIDTH - 1:0] wdata;

	modport source (
		output strobe,
		output op,
		output reg_sel,
		output wdata
	);

	modport sink (
		input strobe,
		input op,
		input reg_sel,
		input wdata
	);

endinterface

`default_nettype wire

//--- hw/timer_core_pkg.sv
`default_nettype none

`include "timer_cfg.svh"

package timer_core_pkg;

	// ****************************************
	// Timer state seen by the read path.
	// ****************************************

	typedef logic [`TIMER_COUNT_WIDTH - 1:0] timer_count_t;

	typedef struct packed {
		// Free-running cycle counters, index 0 is the compare source.
		timer_count_t [`TIMER_NUM_COUNTERS - 1:0] count;
		timer_count_t compare;
		logic [`TIMER_DATA_WIDTH - 1:0] ms;
		logic [`TIMER_NUM_COUNTERS - 1:0] enable;
	} timer_state_t;

endpackage

`default_nettype wire

//--- hw/timer_counters.sv
`timescale 1ns/10ps
`default_nettype none

`include "timer_cfg.svh"

module timer_counters import timer_bus_pkg::*; import timer_core_pkg::*; #(
	parameter int FREQUENCY = `TIMER_FREQUENCY
) (
	input logic i_clock,
	input logic i_reset,
	timer_cmd_if.sink i_cmd,
	output timer_state_t o_state,
	output logic o_interrupt
);

	localparam int PRESCALE = FREQUENCY / 1000;
	localparam int PRESCALE_WIDTH = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
	localparam int N = `TIMER_NUM_COUNTERS;
	localparam int D = `TIMER_DATA_WIDTH;
	localparam int W = `TIMER_COUNT_WIDTH;

	logic [PRESCALE_WIDTH - 1:0] prescale;
	logic [D - 1:0] ms;
	timer_count_t [N - 1:0] count;
	timer_count_t compare;
	logic [N - 1:0] enable;
	logic write;
	logic raise;

	assign write = i_cmd.strobe && (i_cmd.op == OP_WRITE);
	assign raise = write && (i_cmd.reg_sel == REG_RAISE);

	// ****************************************
	// Millisecond time base.
	// ****************************************

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			prescale <= '0;
			ms <= '0;
		end
		else if (prescale == PRESCALE_WIDTH'(PRESCALE - 1)) begin
			prescale <= '0;
			ms <= ms + 1'b1;
		end
		else begin
			prescale <= prescale + 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			count <= '0;
		end
		else begin
			for (int i = 0; i < N; i++) begin
				if (enable[i])
					count[i] <= count[i] + 1'b1;
			end
		end
	end

	// Register writes land at the end of the strobe cycle.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			compare <= '1;
			enable <= '0;
		end
		else if (write) begin
			case (i_cmd.reg_sel)
				REG_CMP_LO: compare[D - 1:0] <= i_cmd.wdata;
				REG_CMP_HI: compare[W - 1:D] <= i_cmd.wdata;
				REG_ENABLE: enable <= i_cmd.wdata[N - 1:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_interrupt <= 1'b0;
		else
			o_interrupt <= raise || (enable[0] && (count[0] == compare));
	end

	assign o_state = '{count: count, compare: compare, ms: ms, enable: enable};

endmodule

`default_nettype wire

//--- hw/timer_read_result.sv
`timescale 1ns/10ps
`default_nettype none

`include "timer_cfg.svh"

module timer_read_result import timer_bus_pkg::*; import timer_core_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	timer_cmd_if.sink i_cmd,
	input timer_state_t i_state,
	output logic [`TIMER_DATA_WIDTH - 1:0] o_rdata,
	output logic o_ready
);

	localparam int D = `TIMER_DATA_WIDTH;
	localparam int W = `TIMER_COUNT_WIDTH;

	logic [D - 1:0] rdata_next;
	logic read;

	assign read = i_cmd.strobe && (i_cmd.op == OP_READ);

	// ****************************************
	// Read data select.
	// ****************************************

	always_comb begin
		rdata_next = '0;
		case (i_cmd.reg_sel)
			REG_MS:      rdata_next = i_state.ms;
			REG_CNT0_LO: rdata_next = i_state.count[0][D - 1:0];
			REG_CNT0_HI: rdata_next = i_state.count[0][W - 1:D];
			REG_CNT1_LO: rdata_next = i_state.count[1][D - 1:0];
			REG_CNT1_HI: rdata_next = i_state.count[1][W - 1:D];
			REG_CNT2_LO: rdata_next = i_state.count[2][D - 1:0];
			REG_CNT2_HI: rdata_next = i_state.count[2][W - 1:D];
			REG_CNT3_LO: rdata_next = i_state.count[3][D - 1:0];
			REG_CNT3_HI: rdata_next = i_state.count[3][W - 1:D];
			REG_CMP_LO:  rdata_next = i_state.compare[D - 1:0];
			REG_CMP_HI:  rdata_next = i_state.compare[W - 1:D];
			REG_ENABLE:  rdata_next = D'(i_state.enable);
			default:     rdata_next = '0;   // unmapped and raise read zero
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (read)
			o_rdata <= rdata_next;
	end

	// Ready holds until the master lets go of the request.
	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_ready <= 1'b0;
		else if (i_cmd.strobe)
			o_ready <= 1'b1;
		else if (!i_request)
			o_ready <= 1'b0;
	end

	// A new command only arrives once the previous handshake has closed.
	strobe_after_release: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_cmd.strobe |-> !o_ready
	);

endmodule

`default_nettype wire

//--- hw/timer_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "timer_cfg.svh"

module timer_top import timer_bus_pkg::*; import timer_core_pkg::*; #(
	parameter int FREQUENCY = `TIMER_FREQUENCY
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input logic i_rw,
	input logic [3:0] i_address,
	input logic [`TIMER_DATA_WIDTH - 1:0] i_wdata,
	output logic [`TIMER_DATA_WIDTH - 1:0] o_rdata,
	output logic o_ready,
	output logic o_interrupt
);

	timer_state_t state;

	timer_cmd_if cmd ();

	timer_bus_decode u_decode (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_request (i_request),
		.i_rw      (i_rw),
		.i_address (timer_reg_e'(i_address)),
		.i_wdata   (i_wdata),
		.o_cmd     (cmd)
	);

	timer_counters #(
		.FREQUENCY (FREQUENCY)
	) u_counters (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_cmd       (cmd),
		.o_state     (state),
		.o_interrupt (o_interrupt)
	);

	timer_read_result u_result (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_request (i_request),
		.i_cmd     (cmd),
		.i_state   (state),
		.o_rdata   (o_rdata),
		.o_ready   (o_ready)
	);

endmodule

`default_nettype wire

//--- include/timer_cfg.svh
`ifndef TIMER_CFG_SVH
`define TIMER_CFG_SVH

// Default clock frequency in Hz.
`define TIMER_FREQUENCY 50000000

// Number of free-running cycle counters.
`define TIMER_NUM_COUNTERS 4

// Cycle counter and compare width.
`define TIMER_COUNT_WIDTH 64

// Bus data width.
`define TIMER_DATA_WIDTH 32

`endif

//--- tests/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 8,
	parameter int DRIVE_DELAY = 2
) (
	output logic o_clock,
	output logic o_reset
);

	initial begin
		o_clock = 1'b0;
		forever #(PERIOD / 2) o_clock = ~o_clock;
	end

	// Reset is released just after a rising edge, like every other input.
	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		#(DRIVE_DELAY);
		o_reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- tests/timer_tb.sv
`timescale 1ns/10ps
`default_nettype none

module timer_tb import timer_bus_pkg::*; ;

	localparam int DRIVE_DELAY = 2;
	localparam int TIMEOUT_CYCLES = 4000;

	logic clock;
	logic reset;
	logic request;
	logic rw;
	logic [3:0] address;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic ready;
	logic interrupt;

	logic [31:0] lfsr_state = 32'hafa8;
	int cycle_count = 0;
	int irq_count = 0;
	int last_irq_cycle = 0;

	// Value check posted by the stimulus and compared at the next edge.
	logic check_en = 1'b0;
	string check_name = "";
	logic [31:0] check_got = '0;
	logic [31:0] check_lo = '0;
	logic [31:0] check_hi = '0;

	tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(8), .DRIVE_DELAY(DRIVE_DELAY)) u_clock_gen (
		.o_clock (clock),
		.o_reset (reset)
	);

	timer_top #(.FREQUENCY(8000)) DUT (
		.i_clock     (clock),
		.i_reset     (reset),
		.i_request   (request),
		.i_rw        (rw),
		.i_address   (address),
		.i_wdata     (wdata),
		.o_rdata     (rdata),
		.o_ready     (ready),
		.o_interrupt (interrupt)
	);

	task automatic report_error(input string message);
		$display("%s", message);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	// ****************************************
	// Checks.
	// ****************************************

	value_in_range: assert property (@(posedge clock)
		check_en |-> (check_got >= check_lo) && (check_got <= check_hi))
		else report_error($sformatf("FAIL %s: got 0x%h, expected 0x%h..0x%h",
			check_name, check_got, check_lo, check_hi));

	reset_quiet: assert property (@(posedge clock) $fell(reset) |-> !ready && !interrupt)
		else report_error($sformatf("FAIL o_ready 0x%h o_interrupt 0x%h after reset",
			ready, interrupt));

	// Ready rises only at a fixed latency after the first sampled request.
	ready_latency: assert property (@(posedge clock) disable iff (reset)
		$past(request, 2) && !$past(request, 3) |-> $rose(ready))
		else report_error("o_ready did not rise two cycles after the request was first sampled");

	ready_source: assert property (@(posedge clock) disable iff (reset)
		$rose(ready) |-> $past(request, 2) && !$past(request, 3))
		else report_error("o_ready rose without a new request two cycles earlier");

	ready_hold: assert property (@(posedge clock) disable iff (reset)
		ready && request |=> ready)
		else report_error("o_ready fell while the request was still held");

	ready_release: assert property (@(posedge clock) disable iff (reset)
		ready && !request |=> !ready)
		else report_error("o_ready stayed high after the request was dropped");

	// A raise write shows up in the cycle after its strobe.
	raise_pulse: assert property (@(posedge clock) disable iff (reset)
		$past(request, 2) && !$past(request, 3) && $past(rw, 2) && ($past(address, 2) == REG_RAISE)
		|-> interrupt)
		else report_error("o_interrupt did not follow a write to the raise register");

	interrupt_single: assert property (@(posedge clock) disable iff (reset)
		interrupt |=> !interrupt)
		else report_error("o_interrupt stayed high for more than one cycle");

	always @(posedge clock) begin
		if (interrupt) begin
			irq_count++;
			last_irq_cycle = cycle_count;
		end
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			report_error($sformatf("Timeout: tests did not finish within %0d cycles",
				TIMEOUT_CYCLES));
	end

	// ****************************************
	// Stimulus helpers.
	// ****************************************

	// Galois LFSR for x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	task automatic draw_bits(input int width, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < width; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic wait_cycles(input int count);
		repeat (count) begin
			@(posedge clock);
			#(DRIVE_DELAY);
		end
	endtask

	// One full handshake. The request is held for extra cycles after ready.
	task automatic bus_access(input logic write, input logic [3:0] addr,
		input logic [31:0] data, input int hold, output logic [31:0] value,
		output int ready_cycle);
		request = 1'b1;
		rw = write;
		address = addr;
		wdata = data;
		do wait_cycles(1); while (!ready);
		value = rdata;
		ready_cycle = cycle_count;
		wait_cycles(hold);
		request = 1'b0;
		do wait_cycles(1); while (ready);
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] value,
		output int ready_cycle);
		bus_access(1'b0, addr, 32'h0, 0, value, ready_cycle);
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
		logic [31:0] ignored_value;
		int ignored_cycle;
		bus_access(1'b1, addr, data, 0, ignored_value, ignored_cycle);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] lo, input logic [31:0] hi);
		check_name = name;
		check_got = got;
		check_lo = lo;
		check_hi = hi;
		check_en = 1'b1;
		wait_cycles(1);
		check_en = 1'b0;
	endtask

	task automatic expect_read(input string name, input logic [3:0] addr,
		input logic [31:0] expected);
		logic [31:0] value;
		int ignored_cycle;
		read_reg(addr, value, ignored_cycle);
		check_value(name, value, expected, expected);
	endtask

	initial begin
		logic [31:0] value;
		logic [31:0] first;
		logic [31:0] data;
		logic [31:0] offset;
		int c1;
		int c2;
		int base;
		request = 1'b0;
		rw = 1'b0;
		address = '0;
		wdata = '0;
		@(negedge reset);

		// The millisecond count is read before its first tick.
		expect_read("REG_MS", REG_MS, 32'h0);
		expect_read("REG_ENABLE", REG_ENABLE, 32'h0);
		for (int a = 1; a <= 8; a++)
			expect_read($sformatf("counter word %0d", a), 4'(a), 32'h0);
		expect_read("REG_CMP_LO", REG_CMP_LO, 32'hffffffff);
		expect_read("REG_CMP_HI", REG_CMP_HI, 32'hffffffff);

		base = irq_count;
		bus_access(1'b1, REG_RAISE, 32'h0, 6, value, c1);
		check_value("held raise interrupt count", irq_count, base + 1, base + 1);

		draw_bits(32, data);
		write_reg(REG_CMP_LO, data);
		expect_read("REG_CMP_LO", REG_CMP_LO, data);
		draw_bits(32, data);
		write_reg(REG_CMP_HI, data);
		expect_read("REG_CMP_HI", REG_CMP_HI, data);
		write_reg(REG_CMP_LO, 32'hffffffff);
		write_reg(REG_CMP_HI, 32'hffffffff);
		draw_bits(32, data);
		write_reg(REG_ENABLE, data);
		expect_read("REG_ENABLE", REG_ENABLE, data & 32'hf);
		write_reg(REG_ENABLE, 32'h0);
		for (int a = 11; a <= 13; a++)
			expect_read($sformatf("unmapped word %0d", a), 4'(a), 32'h0);
		expect_read("REG_RAISE", REG_RAISE, 32'h0);

		write_reg(REG_ENABLE, 32'h2);
		read_reg(REG_CNT1_LO, first, c1);
		read_reg(REG_CNT1_LO, value, c2);
		check_value("REG_CNT1_LO delta", value - first, c2 - c1, c2 - c1);
		read_reg(REG_CNT2_LO, first, c1);
		read_reg(REG_CNT2_LO, value, c2);
		check_value("REG_CNT2_LO hold", value, first, first);

		read_reg(REG_MS, first, c1);
		draw_bits(6, data);
		wait_cycles(data + 10);
		read_reg(REG_MS, value, c2);
		check_value("REG_MS delta", value - first, (c2 - c1) / 8, (c2 - c1 + 7) / 8);

		// Compare lands ahead of counter 0 by a margin above the write latency.
		write_reg(REG_ENABLE, 32'h3);
		write_reg(REG_CMP_HI, 32'h0);
		base = irq_count;
		read_reg(REG_CNT0_LO, first, c1);
		draw_bits(5, offset);
		offset = offset + 16;
		write_reg(REG_CMP_LO, first + offset);
		while (irq_count == base)
			wait_cycles(1);
		check_value("compare interrupt delay", last_irq_cycle - c1, offset, offset);
		wait_cycles(64);
		check_value("compare interrupt count", irq_count, base + 1, base + 1);
		write_reg(REG_RAISE, 32'h0);
		check_value("raise interrupt count", irq_count, base + 2, base + 2);

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire
